/* Bender.yml */
package:
  name: exu

sources:
  - hw/exu_pkg.sv
  - hw/exu_regfile.sv
  - hw/exu_alu.sv
  - hw/exu_lsu.sv
  - hw/exu_commit.sv
  - hw/exu_top.sv
  - target: test
    files:
      - tests/exu_properties.sv
      - tests/exu_tb_mem.sv
      - tests/exu_tb.sv

/* files.f */
hw/exu_pkg.sv
hw/exu_regfile.sv
hw/exu_alu.sv
hw/exu_lsu.sv
hw/exu_commit.sv
hw/exu_top.sv
tests/exu_properties.sv
tests/exu_tb_mem.sv
tests/exu_tb.sv

/* hw/exu_alu.sv */
module exu_alu (
    input  exu_pkg::exu_op_e         op,
    input  logic [exu_pkg::xlen-1:0] pc,
    input  logic [exu_pkg::xlen-1:0] imm,
    input  logic [exu_pkg::xlen-1:0] src1,
    input  logic [exu_pkg::xlen-1:0] src2,
    output logic [exu_pkg::xlen-1:0] alu_result,
    output logic                     alu_write,
    output logic [exu_pkg::xlen-1:0] next_pc,
    output logic [exu_pkg::xlen-1:0] mem_addr_full
);

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
    } alu_mode_e;

    alu_mode_e                            mode;
    logic                                 use_src2;
    logic                                 taken;
    logic [exu_pkg::xlen-1:0]             opa;
    logic [exu_pkg::xlen-1:0]             opb;
    logic [$clog2(exu_pkg::xlen)-1:0]     shamt;
    logic [exu_pkg::xlen-1:0]             res;
    logic [exu_pkg::xlen-1:0]             snpc;
    logic [exu_pkg::xlen-1:0]             br_target;

    // register forms take src2, the rest take imm
    assign use_src2 = op inside {exu_pkg::op_add, exu_pkg::op_sub, exu_pkg::op_and,
                                 exu_pkg::op_or, exu_pkg::op_xor, exu_pkg::op_slt,
                                 exu_pkg::op_sltu, exu_pkg::op_sll, exu_pkg::op_srl,
                                 exu_pkg::op_sra};
    assign opa   = (op == exu_pkg::op_auipc) ? pc : src1;
    assign opb   = use_src2 ? src2 : imm;
    // only the low bits count as shift amount
    assign shamt = opb[$clog2(exu_pkg::xlen)-1:0];

    // add is the default, covers addi, auipc and address math
    always_comb begin
        case (op)
            exu_pkg::op_sub:                     mode = alu_sub;
            exu_pkg::op_and, exu_pkg::op_andi:   mode = alu_and;
            exu_pkg::op_or, exu_pkg::op_ori:     mode = alu_or;
            exu_pkg::op_xor, exu_pkg::op_xori:   mode = alu_xor;
            exu_pkg::op_slt, exu_pkg::op_slti:   mode = alu_slt;
            exu_pkg::op_sltu, exu_pkg::op_sltiu: mode = alu_sltu;
            exu_pkg::op_sll, exu_pkg::op_slli:   mode = alu_sll;
            exu_pkg::op_srl, exu_pkg::op_srli:   mode = alu_srl;
            exu_pkg::op_sra, exu_pkg::op_srai:   mode = alu_sra;
            default:                             mode = alu_add;
        endcase
    end

    always_comb begin
        case (mode)
            alu_sub:  res = opa - opb;
            alu_and:  res = opa & opb;
            alu_or:   res = opa | opb;
            alu_xor:  res = opa ^ opb;
            alu_slt:  res = {{(exu_pkg::xlen-1){1'b0}}, $signed(opa) < $signed(opb)};
            alu_sltu: res = {{(exu_pkg::xlen-1){1'b0}}, opa < opb};
            alu_sll:  res = opa << shamt;
            alu_srl:  res = opa >> shamt;
            alu_sra:  res = $signed(opa) >>> shamt;
            default:  res = opa + opb;
        endcase
    end

    assign snpc          = pc + exu_pkg::inst_bytes;
    assign br_target     = pc + imm;
    assign mem_addr_full = src1 + imm;

    // branches, loads and stores leave the alu result unused
    assign alu_write = !(op inside {[exu_pkg::op_beq:exu_pkg::op_bgeu],
                                    [exu_pkg::op_lb:exu_pkg::op_sd]});

    // link value for jumps, lui passes imm through
    always_comb begin
        case (op)
            exu_pkg::op_lui:                  alu_result = imm;
            exu_pkg::op_jal, exu_pkg::op_jalr: alu_result = snpc;
            default:                          alu_result = res;
        endcase
    end

    // signed compare for blt/bge, unsigned for the u forms
    always_comb begin
        case (op)
            exu_pkg::op_beq:  taken = src1 == src2;
            exu_pkg::op_bne:  taken = src1 != src2;
            exu_pkg::op_blt:  taken = $signed(src1) < $signed(src2);
            exu_pkg::op_bge:  taken = $signed(src1) >= $signed(src2);
            exu_pkg::op_bltu: taken = src1 < src2;
            exu_pkg::op_bgeu: taken = src1 >= src2;
            default:          taken = 1'b0;
        endcase
    end

    // jalr target has bit 0 cleared
    always_comb begin
        case (op)
            exu_pkg::op_jal:  next_pc = br_target;
            exu_pkg::op_jalr: next_pc = {mem_addr_full[exu_pkg::xlen-1:1], 1'b0};
            default:          next_pc = taken ? br_target : snpc;
        endcase
    end

endmodule

/* hw/exu_commit.sv */
module exu_commit (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           issue_req,
    input  exu_pkg::exu_op_e               op,
    input  logic [exu_pkg::reg_addr_w-1:0] rd,
    input  logic [exu_pkg::reg_addr_w-1:0] rs1,
    input  logic [exu_pkg::reg_addr_w-1:0] rs2,
    input  logic [exu_pkg::xlen-1:0]       imm,
    input  logic [exu_pkg::xlen-1:0]       pc,
    input  logic [exu_pkg::xlen-1:0]       alu_result,
    input  logic                           alu_write,
    input  logic [exu_pkg::xlen-1:0]       next_pc,
    input  logic                           lsu_done,
    input  logic [exu_pkg::xlen-1:0]       ld_data,
    input  logic                           ld_write,
    output logic                           issue_ack,
    output logic                           start,
    output exu_pkg::exu_op_e               l_op,
    output logic [exu_pkg::reg_addr_w-1:0] l_rd,
    output logic [exu_pkg::reg_addr_w-1:0] l_rs1,
    output logic [exu_pkg::reg_addr_w-1:0] l_rs2,
    output logic [exu_pkg::xlen-1:0]       l_imm,
    output logic [exu_pkg::xlen-1:0]       l_pc,
    output logic                           wb_valid,
    output logic [exu_pkg::reg_addr_w-1:0] wb_rd,
    output logic [exu_pkg::xlen-1:0]       wb_data,
    output logic [exu_pkg::xlen-1:0]       dnpc
);

    typedef enum logic [1:0] {st_idle, st_exec, st_wait_lsu, st_ack_hold} state_e;

    state_e                   state;
    logic                     commit;
    logic [exu_pkg::xlen-1:0] result;

    assign commit = (state == st_wait_lsu) && lsu_done;
    // load data wins over the alu path
    assign result = ld_write ? ld_data : alu_result;

    // edge 1 latch + start, edge 2 lsu done, edge 3 commit and ack
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            issue_ack <= 1'b0;
            start     <= 1'b0;
            wb_valid  <= 1'b0;
            dnpc      <= exu_pkg::reset_pc;
        end else begin
            start    <= 1'b0;
            wb_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (issue_req) begin
                        start <= 1'b1;
                        state <= st_exec;
                    end
                end
                st_exec: state <= st_wait_lsu;
                st_wait_lsu: begin
                    if (commit) begin
                        issue_ack <= 1'b1;
                        // x0 writes are dropped
                        wb_valid  <= (ld_write || alu_write) && l_rd != '0;
                        dnpc      <= next_pc;
                        state     <= st_ack_hold;
                    end
                end
                st_ack_hold: begin
                    // ack stays up until req is seen low
                    if (!issue_req) begin
                        issue_ack <= 1'b0;
                        state     <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // instruction latch and write-back payload
    always_ff @(posedge clk) begin
        if (state == st_idle && issue_req) begin
            l_op  <= op;
            l_rd  <= rd;
            l_rs1 <= rs1;
            l_rs2 <= rs2;
            l_imm <= imm;
            l_pc  <= pc;
        end
        if (commit) begin
            wb_rd   <= l_rd;
            wb_data <= result;
        end
    end

endmodule

/* hw/exu_lsu.sv */
module exu_lsu (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       start,
    input  exu_pkg::exu_op_e           op,
    input  logic [exu_pkg::xlen-1:0]   addr,
    input  logic [exu_pkg::xlen-1:0]   src2,
    input  logic                       mem_ack,
    input  logic [exu_pkg::xlen-1:0]   mem_rdata,
    output logic                       mem_req,
    output logic                       mem_we,
    output logic [exu_pkg::xlen-1:0]   mem_addr,
    output logic [exu_pkg::xlen-1:0]   mem_wdata,
    output logic [exu_pkg::mask_w-1:0] mem_wmask,
    output logic                       done,
    output logic [exu_pkg::xlen-1:0]   ld_data,
    output logic                       ld_write
);

    typedef enum logic [1:0] {st_idle, st_req, st_wait_drop, st_finish} state_e;

    state_e                      state;
    logic                        is_load;
    logic                        is_store;
    logic [exu_pkg::lane_w-1:0]  lane;
    logic [exu_pkg::mask_w-1:0]  size_mask;
    logic [exu_pkg::xlen-1:0]    rdata_q;
    logic [exu_pkg::xlen-1:0]    rdata_sh;

    assign is_load  = op inside {[exu_pkg::op_lb:exu_pkg::op_lwu]};
    assign is_store = op inside {[exu_pkg::op_sb:exu_pkg::op_sd]};
    assign lane     = addr[exu_pkg::lane_w-1:0];
    // op and addr stay latched in commit until done
    assign ld_write = is_load;

    // store byte enables at lane 0, zero for anything else
    always_comb begin
        case (op)
            exu_pkg::op_sb: size_mask = 8'h01;
            exu_pkg::op_sh: size_mask = 8'h03;
            exu_pkg::op_sw: size_mask = 8'h0f;
            exu_pkg::op_sd: size_mask = 8'hff;
            default:        size_mask = '0;
        endcase
    end

    // four-phase port: req up, wait ack, req down, wait ack low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            mem_req <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start && (is_load || is_store)) begin
                        mem_req <= 1'b1;
                        state   <= st_req;
                    end else if (start) begin
                        // no memory access, done right away
                        done <= 1'b1;
                    end
                end
                st_req: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= st_wait_drop;
                    end
                end
                st_wait_drop: begin
                    if (!mem_ack) begin
                        state <= st_finish;
                    end
                end
                st_finish: begin
                    done  <= 1'b1;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request payload loaded once, held through the handshake
    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            mem_we    <= is_store;
            mem_addr  <= {addr[exu_pkg::xlen-1:exu_pkg::lane_w], {exu_pkg::lane_w{1'b0}}};
            mem_wdata <= src2 << {lane, 3'b000};
            mem_wmask <= size_mask << lane;
        end
        // read data valid only while ack is high
        if (state == st_req && mem_ack) begin
            rdata_q <= mem_rdata;
        end
    end

    // move the addressed bytes down to bit 0
    assign rdata_sh = rdata_q >> {lane, 3'b000};

    always_comb begin
        case (op)
            exu_pkg::op_lb:  ld_data = {{(exu_pkg::xlen-8){rdata_sh[7]}}, rdata_sh[7:0]};
            exu_pkg::op_lh:  ld_data = {{(exu_pkg::xlen-16){rdata_sh[15]}}, rdata_sh[15:0]};
            exu_pkg::op_lw:  ld_data = {{(exu_pkg::xlen-32){rdata_sh[31]}}, rdata_sh[31:0]};
            exu_pkg::op_lbu: ld_data = {{(exu_pkg::xlen-8){1'b0}}, rdata_sh[7:0]};
            exu_pkg::op_lhu: ld_data = {{(exu_pkg::xlen-16){1'b0}}, rdata_sh[15:0]};
            exu_pkg::op_lwu: ld_data = {{(exu_pkg::xlen-32){1'b0}}, rdata_sh[31:0]};
            // ld and non-loads
            default:         ld_data = rdata_q;
        endcase
    end

endmodule

/* hw/exu_pkg.sv */
package exu_pkg;

    // data and address width
    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int nregs      = 32;
    // one enable per byte of a double word
    localparam int mask_w     = xlen / 8;
    // address bits picking the byte inside a double word
    localparam int lane_w     = 3;

    // sequential pc step
    localparam logic [xlen-1:0] inst_bytes = 4;
    // dnpc out of reset
    localparam logic [xlen-1:0] reset_pc   = '0;

    // decoded operation, immediate already selected by decode
    typedef enum logic [5:0] {
        // register forms
        op_add, op_sub, op_and, op_or, op_xor,
        op_slt, op_sltu, op_sll, op_srl, op_sra,
        // immediate forms
        op_addi, op_andi, op_ori, op_xori,
        op_slti, op_sltiu, op_slli, op_srli, op_srai,
        // upper immediates and jumps
        op_lui, op_auipc, op_jal, op_jalr,
        // conditional branches
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        // loads, the u forms zero extend
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        // stores
        op_sb, op_sh, op_sw, op_sd
    } exu_op_e;

endpackage

/* hw/exu_regfile.sv */
module exu_regfile (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          we,
    input  logic [exu_pkg::reg_addr_w-1:0] waddr,
    input  logic [exu_pkg::xlen-1:0]       wdata,
    input  logic [exu_pkg::reg_addr_w-1:0] raddr_a,
    input  logic [exu_pkg::reg_addr_w-1:0] raddr_b,
    output logic [exu_pkg::xlen-1:0]       rdata_a,
    output logic [exu_pkg::xlen-1:0]       rdata_b
);

    logic [exu_pkg::xlen-1:0] regs [exu_pkg::nregs];

    // x0 is never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < exu_pkg::nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 forced to zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

/* hw/exu_top.sv */
module exu_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           issue_req,
    output logic                           issue_ack,
    input  exu_pkg::exu_op_e               op,
    input  logic [exu_pkg::reg_addr_w-1:0] rd,
    input  logic [exu_pkg::reg_addr_w-1:0] rs1,
    input  logic [exu_pkg::reg_addr_w-1:0] rs2,
    input  logic [exu_pkg::xlen-1:0]       imm,
    input  logic [exu_pkg::xlen-1:0]       pc,
    output logic                           wb_valid,
    output logic [exu_pkg::reg_addr_w-1:0] wb_rd,
    output logic [exu_pkg::xlen-1:0]       wb_data,
    output logic [exu_pkg::xlen-1:0]       dnpc,
    output logic                           mem_req,
    output logic                           mem_we,
    output logic [exu_pkg::xlen-1:0]       mem_addr,
    output logic [exu_pkg::xlen-1:0]       mem_wdata,
    output logic [exu_pkg::mask_w-1:0]     mem_wmask,
    input  logic                           mem_ack,
    input  logic [exu_pkg::xlen-1:0]       mem_rdata
);

    // latched instruction
    exu_pkg::exu_op_e               l_op;
    logic [exu_pkg::reg_addr_w-1:0] l_rd;
    logic [exu_pkg::reg_addr_w-1:0] l_rs1;
    logic [exu_pkg::reg_addr_w-1:0] l_rs2;
    logic [exu_pkg::xlen-1:0]       l_imm;
    logic [exu_pkg::xlen-1:0]       l_pc;
    logic                           start;
    // register operands
    logic [exu_pkg::xlen-1:0]       src1;
    logic [exu_pkg::xlen-1:0]       src2;
    // alu path results
    logic [exu_pkg::xlen-1:0]       alu_result;
    logic                           alu_write;
    logic [exu_pkg::xlen-1:0]       next_pc;
    logic [exu_pkg::xlen-1:0]       mem_addr_full;
    // load/store path results
    logic                           lsu_done;
    logic [exu_pkg::xlen-1:0]       ld_data;
    logic                           ld_write;

    exu_commit i_exu_commit (
        .clk(clk), .arst_n(arst_n),
        .issue_req(issue_req), .op(op), .rd(rd), .rs1(rs1), .rs2(rs2),
        .imm(imm), .pc(pc),
        .alu_result(alu_result), .alu_write(alu_write), .next_pc(next_pc),
        .lsu_done(lsu_done), .ld_data(ld_data), .ld_write(ld_write),
        .issue_ack(issue_ack), .start(start),
        .l_op(l_op), .l_rd(l_rd), .l_rs1(l_rs1), .l_rs2(l_rs2),
        .l_imm(l_imm), .l_pc(l_pc),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .dnpc(dnpc)
    );

    exu_alu i_exu_alu (
        .op(l_op), .pc(l_pc), .imm(l_imm), .src1(src1), .src2(src2),
        .alu_result(alu_result), .alu_write(alu_write),
        .next_pc(next_pc), .mem_addr_full(mem_addr_full)
    );

    exu_lsu i_exu_lsu (
        .clk(clk), .arst_n(arst_n), .start(start), .op(l_op),
        .addr(mem_addr_full), .src2(src2),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .done(lsu_done), .ld_data(ld_data), .ld_write(ld_write)
    );

    // write port fed from the registered write-back
    exu_regfile i_exu_regfile (
        .clk(clk), .arst_n(arst_n),
        .we(wb_valid), .waddr(wb_rd), .wdata(wb_data),
        .raddr_a(l_rs1), .raddr_b(l_rs2),
        .rdata_a(src1), .rdata_b(src2)
    );

endmodule

/* tests/exu_properties.sv */
module exu_properties (
    input logic clk,
    input logic arst_n,
    input logic issue_req,
    input logic issue_ack,
    input logic wb_valid,
    input logic mem_req,
    input logic mem_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    // failed assertions, read back by the testbench at the end
    int unsigned fail_count = 0;

    // ack only ever answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(issue_ack) |-> issue_req)
        else begin
            fail_count++;
            $error("issue_ack rose while issue_req was low");
        end

    // ack stays up as long as req is still high
    ack_held: assert property (@(posedge clk) disable iff (!arst_n)
        issue_ack && issue_req |=> issue_ack)
        else begin
            fail_count++;
            $error("issue_ack dropped while issue_req was high");
        end

    // memory request is not withdrawn before the ack
    mem_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req && !mem_ack |=> mem_req)
        else begin
            fail_count++;
            $error("mem_req dropped before mem_ack");
        end

    // write-back pulse comes with the rise of the ack
    wb_with_ack: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid |-> $rose(issue_ack))
        else begin
            fail_count++;
            $error("wb_valid high outside the rise of issue_ack");
        end

endmodule

bind exu_top exu_properties i_exu_properties (
    .clk(clk), .arst_n(arst_n), .issue_req(issue_req), .issue_ack(issue_ack),
    .wb_valid(wb_valid), .mem_req(mem_req), .mem_ack(mem_ack)
);

/* tests/exu_tb.sv */
module exu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ack_timeout = 40;

    typedef struct packed {
        exu_pkg::exu_op_e               op;
        logic [exu_pkg::reg_addr_w-1:0] rd;
        logic [exu_pkg::reg_addr_w-1:0] rs1;
        logic [exu_pkg::reg_addr_w-1:0] rs2;
        logic [exu_pkg::xlen-1:0]       imm;
        logic [exu_pkg::xlen-1:0]       pc;
        logic                           exp_valid;
        logic [exu_pkg::reg_addr_w-1:0] exp_rd;
        logic [exu_pkg::xlen-1:0]       exp_data;
        logic [exu_pkg::xlen-1:0]       exp_dnpc;
    } entry_t;

    logic                           clk = 1'b0;
    logic                           arst_n;
    logic                           issue_req;
    logic                           issue_ack;
    exu_pkg::exu_op_e               op;
    logic [exu_pkg::reg_addr_w-1:0] rd;
    logic [exu_pkg::reg_addr_w-1:0] rs1;
    logic [exu_pkg::reg_addr_w-1:0] rs2;
    logic [exu_pkg::xlen-1:0]       imm;
    logic [exu_pkg::xlen-1:0]       pc;
    logic                           wb_valid;
    logic [exu_pkg::reg_addr_w-1:0] wb_rd;
    logic [exu_pkg::xlen-1:0]       wb_data;
    logic [exu_pkg::xlen-1:0]       dnpc;
    logic                           mem_req;
    logic                           mem_we;
    logic [exu_pkg::xlen-1:0]       mem_addr;
    logic [exu_pkg::xlen-1:0]       mem_wdata;
    logic [exu_pkg::mask_w-1:0]     mem_wmask;
    logic                           mem_ack;
    logic [exu_pkg::xlen-1:0]       mem_rdata;
    entry_t                         table_q[$];
    int                             cur;

    // 40 ns period
    always #20 clk = ~clk;

    exu_top i_exu_top (
        .clk(clk), .arst_n(arst_n), .issue_req(issue_req), .issue_ack(issue_ack),
        .op(op), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm), .pc(pc),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data), .dnpc(dnpc),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    exu_tb_mem i_exu_tb_mem (
        .clk(clk), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .mem_ack(mem_ack), .mem_rdata(mem_rdata)
    );

    task automatic add_entry(input exu_pkg::exu_op_e e_op,
                             input logic [exu_pkg::reg_addr_w-1:0] e_rd,
                             input logic [exu_pkg::reg_addr_w-1:0] e_rs1,
                             input logic [exu_pkg::reg_addr_w-1:0] e_rs2,
                             input logic [63:0] e_imm, input logic [63:0] e_pc,
                             input logic v, input logic [63:0] data, input logic [63:0] npc);
        entry_t e;
        e = '{e_op, e_rd, e_rs1, e_rs2, e_imm, e_pc, v, e_rd, data, npc};
        table_q.push_back(e);
    endtask

    task automatic check_value(input string name, input logic [exu_pkg::xlen-1:0] got,
                               input logic [exu_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s (entry %0d): got 0x%0h, expected 0x%0h", name, cur, got, exp);
            $display("TB FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout in entry %0d: %s", cur, what);
        $display("TB FAILED");
        $fatal(1, "stopping on timeout");
    endtask

    // one full four-phase issue, then the result checks
    task automatic run_entry(input entry_t e);
        int n;
        @(posedge clk);
        issue_req <= 1'b1;
        op        <= e.op;
        rd        <= e.rd;
        rs1       <= e.rs1;
        rs2       <= e.rs2;
        imm       <= e.imm;
        pc        <= e.pc;
        // n counts rising edges after the one that drove req
        n = 0;
        @(negedge clk);
        while (!issue_ack && n < ack_timeout) begin
            @(negedge clk);
            n++;
        end
        if (!issue_ack) timeout_fail("issue_ack never rose");
        // fixed latency only without a memory access
        if (!(e.op inside {[exu_pkg::op_lb:exu_pkg::op_sd]})) begin
            check_value("issue_ack latency", n, 3);
        end
        check_value("wb_valid", wb_valid, e.exp_valid);
        if (e.exp_valid) begin
            check_value("wb_rd", wb_rd, e.exp_rd);
            check_value("wb_data", wb_data, e.exp_data);
        end
        check_value("dnpc", dnpc, e.exp_dnpc);
        @(posedge clk);
        issue_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (issue_ack && n < ack_timeout) begin
            @(negedge clk);
            n++;
        end
        if (issue_ack) timeout_fail("issue_ack never fell");
    endtask

    initial begin
        arst_n    = 1'b0;
        issue_req = 1'b0;
        op        = exu_pkg::op_add;
        rd        = '0;
        rs1       = '0;
        rs2       = '0;
        imm       = '0;
        pc        = '0;
        // x1 = 5, x2 = -3, x19 from lui, x0 write dropped
        add_entry(exu_pkg::op_addi, 1, 0, 0, 64'd5, 64'h100, 1, 64'd5, 64'h104);
        add_entry(exu_pkg::op_addi, 2, 0, 0, -64'sd3, 64'h104, 1, -64'sd3, 64'h108);
        add_entry(exu_pkg::op_lui, 19, 0, 0, 64'h1122334455667788, 64'h108, 1,
                  64'h1122334455667788, 64'h10c);
        add_entry(exu_pkg::op_addi, 0, 1, 0, 64'd7, 64'h10c, 0, 64'd0, 64'h110);
        add_entry(exu_pkg::op_add, 4, 1, 2, 64'd0, 64'h110, 1, 64'd2, 64'h114);
        // x0 read back as zero
        add_entry(exu_pkg::op_sub, 5, 0, 2, 64'd0, 64'h114, 1, 64'd3, 64'h118);
        add_entry(exu_pkg::op_and, 6, 2, 19, 64'd0, 64'h118, 1, 64'h1122334455667788, 64'h11c);
        add_entry(exu_pkg::op_or, 7, 1, 19, 64'd0, 64'h11c, 1, 64'h112233445566778d, 64'h120);
        add_entry(exu_pkg::op_xor, 8, 2, 1, 64'd0, 64'h120, 1, -64'sd8, 64'h124);
        add_entry(exu_pkg::op_slt, 9, 2, 1, 64'd0, 64'h124, 1, 64'd1, 64'h128);
        add_entry(exu_pkg::op_sltu, 10, 2, 1, 64'd0, 64'h128, 1, 64'd0, 64'h12c);
        add_entry(exu_pkg::op_sll, 11, 1, 1, 64'd0, 64'h12c, 1, 64'ha0, 64'h130);
        add_entry(exu_pkg::op_srl, 12, 2, 1, 64'd0, 64'h130, 1, 64'h07ffffffffffffff, 64'h134);
        add_entry(exu_pkg::op_sra, 13, 2, 1, 64'd0, 64'h134, 1, -64'sd1, 64'h138);
        // branches at pc 0x200, each taken then not taken
        // rd field nonzero, still no write-back
        add_entry(exu_pkg::op_beq, 3, 1, 1, 64'h40, 64'h200, 0, 64'd0, 64'h240);
        add_entry(exu_pkg::op_beq, 3, 1, 2, 64'h40, 64'h200, 0, 64'd0, 64'h204);
        add_entry(exu_pkg::op_bne, 3, 1, 2, -64'sd16, 64'h200, 0, 64'd0, 64'h1f0);
        add_entry(exu_pkg::op_bne, 3, 1, 1, -64'sd16, 64'h200, 0, 64'd0, 64'h204);
        add_entry(exu_pkg::op_blt, 3, 2, 1, 64'h40, 64'h200, 0, 64'd0, 64'h240);
        add_entry(exu_pkg::op_blt, 3, 1, 2, 64'h40, 64'h200, 0, 64'd0, 64'h204);
        add_entry(exu_pkg::op_bge, 3, 1, 2, -64'sd16, 64'h200, 0, 64'd0, 64'h1f0);
        add_entry(exu_pkg::op_bge, 3, 2, 1, -64'sd16, 64'h200, 0, 64'd0, 64'h204);
        add_entry(exu_pkg::op_bltu, 3, 1, 2, 64'h40, 64'h200, 0, 64'd0, 64'h240);
        add_entry(exu_pkg::op_bltu, 3, 2, 1, 64'h40, 64'h200, 0, 64'd0, 64'h204);
        add_entry(exu_pkg::op_bgeu, 3, 2, 1, -64'sd16, 64'h200, 0, 64'd0, 64'h1f0);
        add_entry(exu_pkg::op_bgeu, 3, 1, 2, -64'sd16, 64'h200, 0, 64'd0, 64'h204);
        // jalr target 5 + 0x20 with bit 0 cleared
        add_entry(exu_pkg::op_jal, 15, 0, 0, 64'h100, 64'h300, 1, 64'h304, 64'h400);
        add_entry(exu_pkg::op_jalr, 16, 1, 0, 64'h20, 64'h310, 1, 64'h314, 64'h24);
        // base x18 = 0x800, store data x20 = -0x1235
        add_entry(exu_pkg::op_addi, 18, 0, 0, 64'h800, 64'h400, 1, 64'h800, 64'h404);
        add_entry(exu_pkg::op_addi, 20, 0, 0, -64'sh1235, 64'h404, 1, -64'sh1235, 64'h408);
        // stores carry a nonzero rd field too
        add_entry(exu_pkg::op_sd, 3, 18, 19, 64'd0, 64'h408, 0, 64'd0, 64'h40c);
        add_entry(exu_pkg::op_sb, 3, 18, 20, 64'd1, 64'h40c, 0, 64'd0, 64'h410);
        add_entry(exu_pkg::op_sh, 3, 18, 20, 64'd2, 64'h410, 0, 64'd0, 64'h414);
        add_entry(exu_pkg::op_sw, 3, 18, 20, 64'd4, 64'h414, 0, 64'd0, 64'h418);
        // merged double word after the partial stores
        add_entry(exu_pkg::op_ld, 21, 18, 0, 64'd0, 64'h418, 1, 64'hffffedcbedcbcb88, 64'h41c);
        add_entry(exu_pkg::op_lb, 22, 18, 0, 64'd1, 64'h41c, 1, 64'hffffffffffffffcb, 64'h420);
        add_entry(exu_pkg::op_lbu, 23, 18, 0, 64'd1, 64'h420, 1, 64'hcb, 64'h424);
        add_entry(exu_pkg::op_lh, 24, 18, 0, 64'd2, 64'h424, 1, 64'hffffffffffffedcb, 64'h428);
        add_entry(exu_pkg::op_lhu, 25, 18, 0, 64'd2, 64'h428, 1, 64'hedcb, 64'h42c);
        add_entry(exu_pkg::op_lw, 26, 18, 0, 64'd0, 64'h42c, 1, 64'hffffffffedcbcb88, 64'h430);
        add_entry(exu_pkg::op_lwu, 27, 18, 0, 64'd0, 64'h430, 1, 64'hedcbcb88, 64'h434);
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        foreach (table_q[i]) begin
            cur = i;
            run_entry(table_q[i]);
        end
        repeat (2) @(posedge clk);
        if (i_exu_top.i_exu_properties.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "assertion failures during the run");
        end
    end

endmodule

/* tests/exu_tb_mem.sv */
module exu_tb_mem (
    input  logic                       clk,
    input  logic                       mem_req,
    input  logic                       mem_we,
    input  logic [exu_pkg::xlen-1:0]   mem_addr,
    input  logic [exu_pkg::xlen-1:0]   mem_wdata,
    input  logic [exu_pkg::mask_w-1:0] mem_wmask,
    output logic                       mem_ack,
    output logic [exu_pkg::xlen-1:0]   mem_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    // double words keyed by address bits above the lane
    logic [exu_pkg::xlen-1:0] words [longint unsigned];
    integer                   seed = 32'h9f5d_9693;
    int                       delay;
    int                       n;
    longint unsigned          idx;
    logic [exu_pkg::xlen-1:0] word;

    // content of a word never written, built from the whole address
    function automatic logic [exu_pkg::xlen-1:0] fill_word(input longint unsigned key);
        return 64'hc3c3_5a5a_c3c3_5a5a ^ {key[60:0], 3'b000};
    endfunction

    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            if (mem_req === 1'b1 && !mem_ack) begin
                // random ack delay of 0 to 3 cycles
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                idx  = mem_addr >> exu_pkg::lane_w;
                word = words.exists(idx) ? words[idx] : fill_word(idx);
                if (mem_we) begin
                    // only the enabled bytes change
                    for (int b = 0; b < exu_pkg::mask_w; b++) begin
                        if (mem_wmask[b]) begin
                            word[8*b +: 8] = mem_wdata[8*b +: 8];
                        end
                    end
                    words[idx] = word;
                end
                mem_rdata <= word;
                mem_ack   <= 1'b1;
                // hold ack until req seen low, bounded
                n = 0;
                do begin
                    @(posedge clk);
                    n++;
                end while (mem_req && n < 64);
                mem_ack <= 1'b0;
            end
        end
    end

endmodule
